/* Makefile */
VERILATOR ?= verilator
TOP       ?= change_logger_tb
FILELIST  ?= change_logger.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* change_logger.f */
+incdir+include
logic/logger_sample_pkg.sv
logic/logger_stream_pkg.sv
logic/change_framer.sv
logic/sample_fifo.sv
logic/word_serializer.sv
logic/packet_buffer.sv
logic/change_logger.sv
dv/change_logger_properties.sv
dv/change_logger_tb.sv

/* dv/change_logger_properties.sv */
`include "logger_cfg.svh"

module change_logger_properties import logger_sample_pkg::*, logger_stream_pkg::*; (
  input logic         clock,
  input logic         reset_i,
  input logic         sample_valid_i,
  input logic         sample_ready_i,
  input logic         word_valid_i,
  input logic         word_ready_i,
  input logic         word_last_i,
  input sample_word_u word_i,
  input logic         byte_valid_i,
  input logic         byte_ready_i,
  input logic         byte_last_i,
  input byte_t        byte_i,
  input logic         m_valid_i,
  input logic         m_ready_i,
  input logic         m_last_i,
  input byte_t        m_data_i
);

  localparam pkt_level_t max_gap = pkt_level_t'(`LOGGER_MAX_PACKET_BYTES - 1);

  pkt_level_t since_last; // output bytes since the previous last

  always_ff @(posedge clock) begin
    if (reset_i) begin
      since_last <= '0;
    end else if (m_valid_i && m_ready_i) begin
      since_last <= m_last_i ? '0 : since_last + pkt_level_t'(1);
    end
  end

  assert property (@(posedge clock) disable iff (reset_i)
    word_valid_i && !word_ready_i |=> word_valid_i && $stable(word_i) && $stable(word_last_i))
    else $error("Word stream changed while stalled");

  assert property (@(posedge clock) disable iff (reset_i)
    byte_valid_i && !byte_ready_i |=> byte_valid_i && $stable(byte_i) && $stable(byte_last_i))
    else $error("Byte stream changed while stalled");

  assert property (@(posedge clock) disable iff (reset_i)
    m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_data_i) && $stable(m_last_i))
    else $error("Output stream changed while stalled");

  // Every strobe lands in a FIFO with room
  assert property (@(posedge clock) disable iff (reset_i)
    sample_valid_i |-> sample_ready_i)
    else $error("Framer strobed while FIFO was full");

  assert property (@(posedge clock) disable iff (reset_i)
    m_valid_i && m_ready_i && since_last == max_gap |-> m_last_i)
    else $error("Packet longer than the maximum length");

endmodule

bind change_logger change_logger_properties u_props (
  .clock         (clock),
  .reset_i       (reset_i),
  .sample_valid_i(sample_valid),
  .sample_ready_i(sample_ready),
  .word_valid_i  (word_valid),
  .word_ready_i  (word_ready),
  .word_last_i   (word_last),
  .word_i        (fifo_word),
  .byte_valid_i  (byte_valid),
  .byte_ready_i  (byte_ready),
  .byte_last_i   (byte_last),
  .byte_i        (byte_data),
  .m_valid_i     (m_tvalid_o),
  .m_ready_i     (m_tready_i),
  .m_last_i      (m_tlast_o),
  .m_data_i      (m_tdata_o)
);

/* dv/change_logger_tb.sv */
`include "logger_cfg.svh"

module change_logger_tb import logger_stream_pkg::*; ();

  logic                         clock;
  logic                         reset_i;
  logic                         enable_i;
  logic [`LOGGER_SIG_WIDTH-1:0] change_i;
  logic [`LOGGER_IGN_WIDTH-1:0] ignore_i;
  logic                         m_tready_i;
  fifo_level_t                  level_o;
  logic                         m_tvalid_o;
  logic                         m_tlast_o;
  byte_t                        m_tdata_o;

  // Steps from the vector file, kind 1 is a level checkpoint
  int     step_kind[$];
  int     step_en[$];
  int     step_val[$];
  int     step_ign[$];
  int     step_mode[$];
  int     step_cyc[$];
  int     step_inc[$];
  byte_t  exp_byte[$];
  logic   exp_last[$];

  int     seed = 32'h9057;
  int     stim_cycles = 0;
  int     limit = 0;
  int     cycles = 0;
  int     out_count = 0;
  byte_t  want_byte;
  logic   want_last;

  change_logger dut (
    .clock     (clock),
    .reset_i   (reset_i),
    .enable_i  (enable_i),
    .change_i  (change_i),
    .ignore_i  (ignore_i),
    .level_o   (level_o),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %02h actual %02h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %0b actual %0b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_level(input string name, input fifo_level_t exp, input fifo_level_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic read_vectors();
    int         fd;
    int         code;
    logic [7:0] kind;
    string      line;
    int         a, b, c, d, e, f;
    int         i;
    int         k;
    logic [31:0] word;
    fd = $fopen("dv/change_logger_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) break;
      case (kind)
        "#": code = $fgets(line, fd);
        "S": begin
          code = $fscanf(fd, "%h %h %h %d %d %d", a, b, c, d, e, f);
          step_kind.push_back(0);
          step_en.push_back(a);
          step_val.push_back(b);
          step_ign.push_back(c);
          step_mode.push_back(d);
          step_cyc.push_back(e);
          step_inc.push_back(f);
          stim_cycles += e;
        end
        "L": begin
          code = $fscanf(fd, "%h", a);
          step_kind.push_back(1);
          step_en.push_back(0);
          step_val.push_back(a);
          step_ign.push_back(0);
          step_mode.push_back(0);
          step_cyc.push_back(0);
          step_inc.push_back(0);
        end
        "E": begin
          code = $fscanf(fd, "%h %h %h %d", a, b, c, e);
          for (i = 0; i < e; i++) begin
            word = {16'(a), 16'(b + i)}; // companion bits above watched bits
            for (k = 0; k < 4; k++) begin
              exp_byte.push_back(word[8*k +: 8]);
              exp_last.push_back((c != 0) && (i == e - 1) && (k == 3));
            end
          end
        end
        default: begin
          $display("Unknown record kind in the vector file");
          stop_with_failure();
        end
      endcase
    end
    $fclose(fd);
  endtask

  // Scoreboard on every output transfer
  always @(posedge clock) begin
    if (!reset_i && m_tvalid_o && m_tready_i) begin
      if (exp_byte.size() == 0) begin
        $display("Output byte %02h arrived when no byte was expected", m_tdata_o);
        stop_with_failure();
      end else begin
        want_byte = exp_byte.pop_front();
        want_last = exp_last.pop_front();
        check_byte($sformatf("byte %0d data", out_count), want_byte, m_tdata_o);
        check_last($sformatf("byte %0d last", out_count), want_last, m_tlast_o);
        out_count++;
      end
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, output stopped before all bytes arrived", cycles);
      stop_with_failure();
    end
  end

  initial begin
    int s;
    int c;
    reset_i    = 1'b1;
    enable_i   = 1'b0;
    change_i   = '0;
    ignore_i   = '0;
    m_tready_i = 1'b0;
    read_vectors();
    limit = 8 + stim_cycles + 40 * exp_byte.size();
    repeat (8) @(posedge clock);
    reset_i <= 1'b0;
    for (s = 0; s < step_kind.size(); s++) begin
      if (step_kind[s] == 1) begin
        @(negedge clock);
        check_level($sformatf("level at step %0d", s), fifo_level_t'(step_val[s]), level_o);
      end else begin
        for (c = 0; c < step_cyc[s]; c++) begin
          @(posedge clock);
          enable_i   <= 1'(step_en[s]);
          change_i   <= 16'(step_val[s] + ((step_inc[s] != 0) ? c : 0));
          ignore_i   <= 16'(step_ign[s]);
          m_tready_i <= (step_mode[s] == 2) ? 1'($random(seed)) : (step_mode[s] == 1);
        end
      end
    end
    @(posedge clock);
    m_tready_i <= 1'b1;
    while (exp_byte.size() != 0) begin
      @(posedge clock);
    end
    repeat (4) @(posedge clock);
    if (!m_tvalid_o) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Output still valid after all expected bytes");
      stop_with_failure();
    end
  end

endmodule

/* dv/change_logger_vectors.txt */
# S enable change ignore ready_mode cycles step  (ready_mode 0 low 1 high 2 random, step adds 1 per cycle)
# E ignore first_watched last count = expected words, L level = sample FIFO level checkpoint
# Disabled, then enabled with change held at all ones
S 0 0000 0000 1 4 0
L 00
S 1 ffff 0000 1 6 0
L 00
# One full packet with ready high
S 1 0001 1111 1 8 1
S 1 0008 1111 1 40 0
L 00
E 1111 0001 1 8
# Random ready
S 1 0100 2222 2 8 1
S 1 0107 2222 2 80 0
L 00
E 2222 0100 1 8
# Enable drop after three samples, forced last at 32 bytes
S 1 0200 3333 1 3 1
S 0 0202 3333 1 2 0
S 1 0202 4444 1 8 1
S 1 0209 4444 1 80 0
L 00
E 3333 0200 0 3
E 4444 0202 1 5
E 4444 0207 1 3
# Ready low until the packet buffer fills, then drain
S 1 0300 5555 0 10 1
S 1 0309 5555 0 50 0
S 1 030a 5555 0 10 1
S 1 0313 5555 0 60 0
L 03
S 1 0314 5555 1 4 1
S 1 0317 5555 1 100 0
L 00
E 5555 0300 1 8
E 5555 0308 1 8
E 5555 0310 1 8

/* include/logger_cfg.svh */
`ifndef LOGGER_CFG_SVH
`define LOGGER_CFG_SVH

// Change detection covers the watched bits only
`define LOGGER_SIG_WIDTH 16
`define LOGGER_IGN_WIDTH 16
`define LOGGER_WORD_WIDTH 32

// Samples per packet, last flag on the final one
`define LOGGER_PACKET_SAMPLES 8

// Storage sizes
`define LOGGER_FIFO_DEPTH 16 // sample words
`define LOGGER_PKT_DEPTH 64  // packet bytes

// Packet buffer closes a packet here even without a last
`define LOGGER_MAX_PACKET_BYTES 32

`endif

/* logic/change_framer.sv */
`include "logger_cfg.svh"

module change_framer import logger_sample_pkg::*; (
  input  logic                         clock,
  input  logic                         reset_i,
  input  logic                         enable_i,
  input  logic [`LOGGER_SIG_WIDTH-1:0] change_i,
  input  logic [`LOGGER_IGN_WIDTH-1:0] ignore_i,
  input  logic                         sample_ready_i,
  output logic                         sample_valid_o,
  output logic                         sample_last_o,
  output sample_word_u                 sample_o
);

  localparam sample_count_t last_count = sample_count_t'(`LOGGER_PACKET_SAMPLES - 1);

  logic [`LOGGER_SIG_WIDTH-1:0] curr_q; // previous watched value
  logic [`LOGGER_IGN_WIDTH-1:0] rest_q;
  sample_count_t                count_q;
  logic                         capture;

  // A dropped change is lost for good, as the reference value moves on anyway
  assign capture = sample_ready_i && (change_i != curr_q);

  always_ff @(posedge clock) begin
    if (reset_i || !enable_i) begin
      curr_q         <= '1; // next change compares against all ones
      count_q        <= '0;
      sample_valid_o <= 1'b0;
      sample_last_o  <= 1'b0;
    end else begin
      curr_q         <= change_i;
      sample_valid_o <= capture;
      sample_last_o  <= capture && (count_q == last_count);
      if (capture) begin
        count_q <= count_q + sample_count_t'(1); // wraps after the eighth sample
      end
    end
  end

  always_ff @(posedge clock) begin
    rest_q <= ignore_i;
  end

  always_comb begin
    sample_o.fields.ign = rest_q;
    sample_o.fields.sig = curr_q;
  end

endmodule

/* logic/change_logger.sv */
`include "logger_cfg.svh"

module change_logger import logger_sample_pkg::*, logger_stream_pkg::*; (
  input  logic                         clock,
  input  logic                         reset_i,
  input  logic                         enable_i,
  input  logic [`LOGGER_SIG_WIDTH-1:0] change_i,
  input  logic [`LOGGER_IGN_WIDTH-1:0] ignore_i,
  output fifo_level_t                  level_o,
  output logic                         m_tvalid_o,
  input  logic                         m_tready_i,
  output logic                         m_tlast_o,
  output byte_t                        m_tdata_o
);

  // Framer to FIFO
  logic         sample_valid;
  logic         sample_last;
  logic         sample_ready;
  sample_word_u sample_word;

  // FIFO to serializer
  logic         word_valid;
  logic         word_last;
  logic         word_ready;
  sample_word_u fifo_word;

  // Serializer to packet buffer
  logic         byte_valid;
  logic         byte_last;
  logic         byte_ready;
  byte_t        byte_data;

  change_framer u_framer (
    .clock         (clock),
    .reset_i       (reset_i),
    .enable_i      (enable_i),
    .change_i      (change_i),
    .ignore_i      (ignore_i),
    .sample_ready_i(sample_ready),
    .sample_valid_o(sample_valid),
    .sample_last_o (sample_last),
    .sample_o      (sample_word)
  );

  sample_fifo u_fifo (
    .clock     (clock),
    .reset_i   (reset_i),
    .wr_valid_i(sample_valid),
    .wr_last_i (sample_last),
    .wr_word_i (sample_word),
    .wr_ready_o(sample_ready),
    .rd_valid_o(word_valid),
    .rd_last_o (word_last),
    .rd_word_o (fifo_word),
    .rd_ready_i(word_ready),
    .level_o   (level_o)
  );

  word_serializer u_serializer (
    .clock       (clock),
    .reset_i     (reset_i),
    .word_valid_i(word_valid),
    .word_last_i (word_last),
    .word_i      (fifo_word),
    .word_ready_o(word_ready),
    .byte_valid_o(byte_valid),
    .byte_last_o (byte_last),
    .byte_o      (byte_data),
    .byte_ready_i(byte_ready)
  );

  packet_buffer u_packet (
    .clock    (clock),
    .reset_i  (reset_i),
    .s_valid_i(byte_valid),
    .s_last_i (byte_last),
    .s_data_i (byte_data),
    .s_ready_o(byte_ready),
    .m_valid_o(m_tvalid_o),
    .m_last_o (m_tlast_o),
    .m_data_o (m_tdata_o),
    .m_ready_i(m_tready_i)
  );

endmodule

/* logic/logger_sample_pkg.sv */
`include "logger_cfg.svh"

package logger_sample_pkg;

  // Companion bits above the watched bits
  typedef struct packed {
    logic [`LOGGER_IGN_WIDTH-1:0] ign;
    logic [`LOGGER_SIG_WIDTH-1:0] sig;
  } sample_fields_t;

  // Framer builds fields, serializer walks bytes
  typedef union packed {
    sample_fields_t                        fields;
    logic [`LOGGER_WORD_WIDTH/8-1:0][7:0]  bytes; // index 0 is sent first
  } sample_word_u;

  // Position of a sample inside its packet
  typedef logic [$clog2(`LOGGER_PACKET_SAMPLES)-1:0] sample_count_t;

endpackage

/* logic/logger_stream_pkg.sv */
`include "logger_cfg.svh"

package logger_stream_pkg;

  typedef logic [7:0] byte_t;

  // One extra bit so a full store is distinct from an empty one
  typedef logic [$clog2(`LOGGER_FIFO_DEPTH):0] fifo_level_t;

  // Also used as packet buffer pointer width
  typedef logic [$clog2(`LOGGER_PKT_DEPTH):0] pkt_level_t;

endpackage

/* logic/packet_buffer.sv */
`include "logger_cfg.svh"

module packet_buffer import logger_stream_pkg::*; (
  input  logic  clock,
  input  logic  reset_i,
  input  logic  s_valid_i,
  input  logic  s_last_i,
  input  byte_t s_data_i,
  output logic  s_ready_o,
  output logic  m_valid_o,
  output logic  m_last_o,
  output byte_t m_data_o,
  input  logic  m_ready_i
);

  localparam int depth   = `LOGGER_PKT_DEPTH;
  localparam int abits   = $clog2(depth);
  localparam int max_len = `LOGGER_MAX_PACKET_BYTES;
  localparam int lbits   = $clog2(max_len);

  logic [$bits(byte_t):0] mem [depth]; // last flag beside each byte
  pkt_level_t             wr_ptr;
  pkt_level_t             rd_ptr;
  pkt_level_t             commit_ptr; // end of the newest complete packet
  pkt_level_t             level;
  logic [lbits-1:0]       len_q;      // bytes since the previous close
  logic                   wr_en;
  logic                   rd_en;
  logic                   at_limit;
  logic                   close;

  assign level     = wr_ptr - rd_ptr;
  assign s_ready_o = level != pkt_level_t'(depth);
  assign wr_en     = s_valid_i && s_ready_o;

  // Byte number max_len of a packet gets a last flag whatever came in
  assign at_limit = len_q == lbits'(max_len - 1);
  assign close    = wr_en && (s_last_i || at_limit);

  // Partial packets sit above the commit point and stay hidden
  assign m_valid_o = rd_ptr != commit_ptr;
  assign rd_en     = m_valid_o && m_ready_i;

  assign {m_last_o, m_data_o} = mem[rd_ptr[abits-1:0]];

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr[abits-1:0]] <= {s_last_i || at_limit, s_data_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      commit_ptr <= '0;
      len_q      <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + pkt_level_t'(1);
      end
      if (close) begin
        commit_ptr <= wr_ptr + pkt_level_t'(1); // include the byte just written
        len_q      <= '0;
      end else if (wr_en) begin
        len_q <= len_q + lbits'(1);
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + pkt_level_t'(1);
      end
    end
  end

endmodule

/* logic/sample_fifo.sv */
`include "logger_cfg.svh"

module sample_fifo import logger_sample_pkg::*, logger_stream_pkg::*; #(
  parameter int depth = `LOGGER_FIFO_DEPTH // power of two
) (
  input  logic         clock,
  input  logic         reset_i,
  input  logic         wr_valid_i,
  input  logic         wr_last_i,
  input  sample_word_u wr_word_i,
  output logic         wr_ready_o,
  output logic         rd_valid_o,
  output logic         rd_last_o,
  output sample_word_u rd_word_o,
  input  logic         rd_ready_i,
  output fifo_level_t  level_o
);

  localparam int abits = $clog2(depth);

  logic [`LOGGER_WORD_WIDTH:0] mem [depth]; // last flag in the top bit
  logic [abits:0]              wr_ptr;
  logic [abits:0]              rd_ptr;
  logic [abits:0]              used;
  logic                        wr_en;
  logic                        load;

  assign used       = wr_ptr - rd_ptr;
  assign wr_ready_o = used != (abits + 1)'(depth);
  assign wr_en      = wr_valid_i && wr_ready_o;

  // Refill the output register when empty or being drained
  assign load = (used != '0) && (!rd_valid_o || rd_ready_i);

  assign level_o = fifo_level_t'(used + (abits + 1)'(rd_valid_o));

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr[abits-1:0]] <= {wr_last_i, wr_word_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + (abits + 1)'(1);
      end
      if (load) begin
        rd_ptr     <= rd_ptr + (abits + 1)'(1);
        rd_valid_o <= 1'b1;
      end else if (rd_ready_i) begin
        rd_valid_o <= 1'b0; // drained with nothing behind it
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      {rd_last_o, rd_word_o} <= mem[rd_ptr[abits-1:0]];
    end
  end

endmodule

/* logic/word_serializer.sv */
`include "logger_cfg.svh"

module word_serializer import logger_sample_pkg::*, logger_stream_pkg::*; (
  input  logic         clock,
  input  logic         reset_i,
  input  logic         word_valid_i,
  input  logic         word_last_i,
  input  sample_word_u word_i,
  output logic         word_ready_o,
  output logic         byte_valid_o,
  output logic         byte_last_o,
  output byte_t        byte_o,
  input  logic         byte_ready_i
);

  localparam int nbytes = `LOGGER_WORD_WIDTH / 8;
  localparam int ibits  = $clog2(nbytes);
  localparam logic [ibits-1:0] last_idx = ibits'(nbytes - 1);

  sample_word_u     word_q;
  logic             last_q;
  logic             full_q;
  logic [ibits-1:0] idx_q;
  logic             final_byte;
  logic             byte_done;
  logic             take_word;

  assign final_byte = idx_q == last_idx;
  assign byte_done  = full_q && byte_ready_i;

  // Next word can slide in on the same edge as the final byte leaves
  assign word_ready_o = !full_q || (byte_done && final_byte);
  assign take_word    = word_valid_i && word_ready_o;

  assign byte_valid_o = full_q;
  assign byte_o       = word_q.bytes[idx_q]; // least significant first
  assign byte_last_o  = last_q && final_byte;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else if (take_word) begin
      full_q <= 1'b1;
      idx_q  <= '0;
    end else if (byte_done) begin
      idx_q <= idx_q + ibits'(1);
      if (final_byte) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take_word) begin
      word_q <= word_i;
      last_q <= word_last_i;
    end
  end

endmodule
